// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_scan_ctrl
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/cfg_execute.sv ====
`default_nettype none

module cfg_execute #(
    parameter int PAYLOAD_BYTES = 26
) (
    input  wire                    clk,
    input  wire                    reset,
    cmd_if.sink                    cmd,
    reply_if.source                reply,
    output logic [2:0]             start_o,
    output scan_cfg_pkg::coord_t   nx_pix_o,
    output scan_cfg_pkg::coord_t   ny_pix_o,
    output scan_cfg_pkg::time_t    pixel_time_o
);

    localparam int NB    = scan_cfg_pkg::NUM_BANKS;
    localparam int CNT_W = $clog2(scan_cfg_pkg::START_CYCLES + 1);

    link_pkg::byte_t [PAYLOAD_BYTES-1:0] bank_q [NB];
    scan_cfg_pkg::bank_e                 wr_bank;
    scan_cfg_pkg::bank_e                 rep_bank_q;
    logic                                req_q;
    logic [CNT_W-1:0]                    start_cnt_q;
    logic [2:0]                          start_sel;
    logic                                is_cfg;
    logic                                accept;

    // busy while a start pulse runs or a reply waits
    assign accept  = cmd.cmd_valid && (start_o == 3'b000) && !req_q;
    assign wr_bank = scan_cfg_pkg::bank_e'(cmd.cmd[1:0]);

    always_comb begin
        is_cfg    = 1'b0;
        start_sel = 3'b000;
        case (cmd.cmd)
            link_pkg::CMD_SCAN, link_pkg::CMD_CONTROL_I,
            link_pkg::CMD_CONTROL_II, link_pkg::CMD_GATE: is_cfg = 1'b1;
            link_pkg::CMD_START_I:   start_sel = 3'b001;
            link_pkg::CMD_START_II:  start_sel = 3'b010;
            link_pkg::CMD_START_III: start_sel = 3'b100;
            default: ; // unknown address dropped
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < NB; b++) begin
                bank_q[b] <= '0;
            end
            rep_bank_q  <= scan_cfg_pkg::BANK_SCAN;
            req_q       <= 1'b0;
            start_o     <= 3'b000;
            start_cnt_q <= '0;
        end else begin
            if (accept && is_cfg) begin
                for (int i = 0; i < PAYLOAD_BYTES; i++) begin
                    if (i < scan_cfg_pkg::BANK_USED[wr_bank]) begin
                        bank_q[wr_bank][i] <= cmd.payload[i];
                    end
                end
                rep_bank_q <= wr_bank;
                req_q      <= 1'b1;
            end else if (reply.ack) begin
                req_q <= 1'b0;
            end

            if (accept && start_sel != 3'b000) begin
                start_o     <= start_sel;
                start_cnt_q <= CNT_W'(scan_cfg_pkg::START_CYCLES - 1);
            end else if (start_cnt_q != '0) begin
                start_cnt_q <= start_cnt_q - 1'b1;
            end else begin
                start_o <= 3'b000;
            end
        end
    end

    // reply image, unused positions padded
    always_comb begin
        for (int i = 0; i < PAYLOAD_BYTES; i++) begin
            if (i < scan_cfg_pkg::BANK_USED[rep_bank_q]) begin
                reply.image[i] = bank_q[rep_bank_q][i];
            end else begin
                reply.image[i] = scan_cfg_pkg::FILL_BYTE;
            end
        end
    end

    assign reply.req  = req_q;
    assign reply.bank = rep_bank_q;

    assign nx_pix_o = {bank_q[scan_cfg_pkg::BANK_SCAN][scan_cfg_pkg::NX_PIX_OFS],
                       bank_q[scan_cfg_pkg::BANK_SCAN][scan_cfg_pkg::NX_PIX_OFS + 1]};
    assign ny_pix_o = {bank_q[scan_cfg_pkg::BANK_SCAN][scan_cfg_pkg::NY_PIX_OFS],
                       bank_q[scan_cfg_pkg::BANK_SCAN][scan_cfg_pkg::NY_PIX_OFS + 1]};
    assign pixel_time_o = {bank_q[scan_cfg_pkg::BANK_SCAN][scan_cfg_pkg::PIXEL_TIME_OFS],
                           bank_q[scan_cfg_pkg::BANK_SCAN][scan_cfg_pkg::PIXEL_TIME_OFS + 1],
                           bank_q[scan_cfg_pkg::BANK_SCAN][scan_cfg_pkg::PIXEL_TIME_OFS + 2],
                           bank_q[scan_cfg_pkg::BANK_SCAN][scan_cfg_pkg::PIXEL_TIME_OFS + 3]};

    a_start_onehot : assert property (@(posedge clk) disable iff (reset)
        $onehot0(start_o));

    a_req_hold : assert property (@(posedge clk) disable iff (reset)
        req_q && !reply.ack |=> req_q);

endmodule

`default_nettype wire

// ==== hw/crc8_calc.sv ====
`default_nettype none

module crc8_calc (
    input  wire                clk,
    input  wire                reset,
    input  wire                clear_i,
    input  wire                valid_i,
    input  wire link_pkg::byte_t data_i,
    output link_pkg::byte_t    crc_o
);

    function automatic link_pkg::byte_t crc_step(link_pkg::byte_t crc, link_pkg::byte_t data);
        link_pkg::byte_t c;
        c = crc ^ data;
        for (int i = 0; i < 8; i++) begin
            c = c[7] ? ((c << 1) ^ link_pkg::CRC_POLY) : (c << 1);
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (reset || clear_i) begin
            crc_o <= link_pkg::CRC_INIT;
        end else if (valid_i) begin
            crc_o <= crc_step(crc_o, data_i);
        end
    end

endmodule

`default_nettype wire

// ==== hw/frame_decode.sv ====
`default_nettype none

module frame_decode #(
    parameter int PAYLOAD_BYTES = 26
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  rx_valid_i,
    input  wire link_pkg::byte_t rx_data_i,
    output logic                 crc_err_o,
    cmd_if.source                cmd
);

    localparam int IDX_W = $clog2(PAYLOAD_BYTES);

    typedef enum logic [1:0] {IDLE, ADDR, DATA, CHECK} state_e;

    state_e                              state_q;
    logic [IDX_W-1:0]                    idx_q;
    logic                                cmd_valid_q;
    link_pkg::byte_t                     addr_q;
    link_pkg::byte_t [PAYLOAD_BYTES-1:0] payload_q;
    link_pkg::byte_t                     crc;
    logic                                crc_step;

    assign crc_step = rx_valid_i && (state_q == ADDR || state_q == DATA);

    crc8_calc u_crc (
        .clk     (clk),
        .reset   (reset),
        .clear_i (state_q == IDLE),
        .valid_i (crc_step),
        .data_i  (rx_data_i),
        .crc_o   (crc)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= IDLE;
            idx_q       <= '0;
            cmd_valid_q <= 1'b0;
            crc_err_o   <= 1'b0;
        end else begin
            cmd_valid_q <= 1'b0;
            crc_err_o   <= 1'b0;
            if (rx_valid_i) begin
                case (state_q)
                    IDLE: begin
                        if (rx_data_i == link_pkg::FRAME_HEADER) begin
                            state_q <= ADDR;
                        end
                    end
                    ADDR: begin
                        idx_q   <= '0;
                        state_q <= DATA;
                    end
                    DATA: begin
                        idx_q <= idx_q + 1'b1;
                        if (idx_q == IDX_W'(PAYLOAD_BYTES - 1)) begin
                            state_q <= CHECK;
                        end
                    end
                    default: begin // check byte
                        cmd_valid_q <= (rx_data_i == crc);
                        crc_err_o   <= (rx_data_i != crc);
                        state_q     <= IDLE;
                    end
                endcase
            end
        end
    end

    // frame contents
    always_ff @(posedge clk) begin
        if (rx_valid_i && state_q == ADDR) begin
            addr_q <= rx_data_i;
        end
        if (rx_valid_i && state_q == DATA) begin
            payload_q[idx_q] <= rx_data_i;
        end
    end

    assign cmd.cmd_valid = cmd_valid_q;
    assign cmd.cmd       = link_pkg::cmd_e'(addr_q); // unknown codes pass through
    assign cmd.payload   = payload_q;

    a_cmd_single : assert property (@(posedge clk) disable iff (reset)
        cmd_valid_q |=> !cmd_valid_q);

endmodule

`default_nettype wire

// ==== hw/link_pkg.sv ====
`default_nettype none

package link_pkg;

    typedef logic [7:0] byte_t;

    // frame: header, address, payload, check byte
    localparam byte_t FRAME_HEADER = 8'hA5;

    // crc-8, msb first over address and payload
    localparam byte_t CRC_POLY = 8'h07;
    localparam byte_t CRC_INIT = 8'h00;

    // frame address codes
    typedef enum logic [7:0] {
        CMD_SCAN       = 8'h00,
        CMD_CONTROL_I  = 8'h01,
        CMD_CONTROL_II = 8'h02,
        CMD_GATE       = 8'h03,
        CMD_START_I    = 8'h04,
        CMD_START_II   = 8'h05,
        CMD_START_III  = 8'h06
    } cmd_e;

endpackage

`default_nettype wire

// ==== hw/reply_result.sv ====
`default_nettype none

module reply_result #(
    parameter int PAYLOAD_BYTES = 26
) (
    input  wire                  clk,
    input  wire                  reset,
    reply_if.sink                reply,
    output logic                 tx_valid_o,
    output link_pkg::byte_t      tx_data_o,
    input  wire                  tx_ready_i
);

    localparam int IDX_W = $clog2(PAYLOAD_BYTES);

    typedef enum logic [2:0] {IDLE, HEAD, ADDR, DATA, CRC} state_e;

    state_e                              state_q;
    logic [IDX_W-1:0]                    idx_q;
    scan_cfg_pkg::bank_e                 bank_q;
    link_pkg::byte_t [PAYLOAD_BYTES-1:0] image_q;
    link_pkg::byte_t                     crc;
    logic                                xfer;

    assign tx_valid_o = (state_q != IDLE);
    assign xfer       = tx_valid_o && tx_ready_i;
    assign reply.ack  = (state_q == IDLE) && reply.req; // latch happens on this edge

    always_comb begin
        case (state_q)
            HEAD:    tx_data_o = link_pkg::FRAME_HEADER;
            ADDR:    tx_data_o = link_pkg::byte_t'(bank_q); // bank code = command code
            DATA:    tx_data_o = image_q[idx_q];
            CRC:     tx_data_o = crc;
            default: tx_data_o = '0;
        endcase
    end

    crc8_calc u_crc (
        .clk     (clk),
        .reset   (reset),
        .clear_i (state_q == IDLE),
        .valid_i (xfer && (state_q == ADDR || state_q == DATA)),
        .data_i  (tx_data_o),
        .crc_o   (crc)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            idx_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (reply.req) begin
                        state_q <= HEAD;
                    end
                end
                HEAD: begin
                    if (xfer) begin
                        state_q <= ADDR;
                    end
                end
                ADDR: begin
                    if (xfer) begin
                        idx_q   <= '0;
                        state_q <= DATA;
                    end
                end
                DATA: begin
                    if (xfer) begin
                        idx_q <= idx_q + 1'b1;
                        if (idx_q == IDX_W'(PAYLOAD_BYTES - 1)) begin
                            state_q <= CRC;
                        end
                    end
                end
                default: begin
                    if (xfer) begin
                        state_q <= IDLE; // last byte out
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reply.ack) begin
            image_q <= reply.image;
            bank_q  <= reply.bank;
        end
    end

    a_tx_hold : assert property (@(posedge clk) disable iff (reset)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o));

endmodule

`default_nettype wire

// ==== hw/scan_cfg_pkg.sv ====
`default_nettype none

package scan_cfg_pkg;

    // order matches the configuration command codes
    typedef enum logic [1:0] {
        BANK_SCAN,
        BANK_CONTROL_I,
        BANK_CONTROL_II,
        BANK_GATE
    } bank_e;

    localparam int NUM_BANKS = 4;

    // bytes actually held per bank
    localparam int unsigned BANK_USED [NUM_BANKS] = '{16, 18, 19, 13};

    localparam link_pkg::byte_t FILL_BYTE = 8'hF0; // pad for unused reply bytes

    localparam int START_CYCLES = 4;

    // scan bank geometry, big-endian
    localparam int NX_PIX_OFS     = 0;
    localparam int NY_PIX_OFS     = 2;
    localparam int PIXEL_TIME_OFS = 12;

    typedef logic [15:0] coord_t;
    typedef logic [31:0] time_t;

endpackage

`default_nettype wire

// ==== hw/scan_ctrl_ifs.sv ====
`default_nettype none

// decoded command, valid for one cycle
interface cmd_if #(
    parameter int PAYLOAD_BYTES = 26
);
    logic                                        cmd_valid;
    link_pkg::cmd_e                              cmd;
    link_pkg::byte_t [PAYLOAD_BYTES-1:0]         payload;

    modport source (output cmd_valid, cmd, payload);
    modport sink   (input  cmd_valid, cmd, payload);
endinterface

// reply request, req held until ack
interface reply_if #(
    parameter int PAYLOAD_BYTES = 26
);
    logic                                        req;
    logic                                        ack;
    scan_cfg_pkg::bank_e                         bank;
    link_pkg::byte_t [PAYLOAD_BYTES-1:0]         image; // already padded

    modport source (output req, bank, image, input ack);
    modport sink   (input  req, bank, image, output ack);
endinterface

`default_nettype wire

// ==== hw/scan_ctrl_top.sv ====
`default_nettype none

module scan_ctrl_top #(
    parameter int PAYLOAD_BYTES = 26
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    rx_valid_i,
    input  wire link_pkg::byte_t   rx_data_i,
    output logic                   tx_valid_o,
    output link_pkg::byte_t        tx_data_o,
    input  wire                    tx_ready_i,
    output logic                   crc_err_o,
    output logic [2:0]             start_o,
    output scan_cfg_pkg::coord_t   nx_pix_o,
    output scan_cfg_pkg::coord_t   ny_pix_o,
    output scan_cfg_pkg::time_t    pixel_time_o
);

    // largest bank is 19 bytes
    if (PAYLOAD_BYTES < 19) begin : g_payload_check
        $error("PAYLOAD_BYTES too small for control II bank");
    end

    cmd_if   #(.PAYLOAD_BYTES(PAYLOAD_BYTES)) u_cmd_if ();
    reply_if #(.PAYLOAD_BYTES(PAYLOAD_BYTES)) u_reply_if ();

    frame_decode #(.PAYLOAD_BYTES(PAYLOAD_BYTES)) u_decode (
        .clk        (clk),
        .reset      (reset),
        .rx_valid_i (rx_valid_i),
        .rx_data_i  (rx_data_i),
        .crc_err_o  (crc_err_o),
        .cmd        (u_cmd_if.source)
    );

    cfg_execute #(.PAYLOAD_BYTES(PAYLOAD_BYTES)) u_execute (
        .clk          (clk),
        .reset        (reset),
        .cmd          (u_cmd_if.sink),
        .reply        (u_reply_if.source),
        .start_o      (start_o),
        .nx_pix_o     (nx_pix_o),
        .ny_pix_o     (ny_pix_o),
        .pixel_time_o (pixel_time_o)
    );

    reply_result #(.PAYLOAD_BYTES(PAYLOAD_BYTES)) u_result (
        .clk        (clk),
        .reset      (reset),
        .reply      (u_reply_if.sink),
        .tx_valid_o (tx_valid_o),
        .tx_data_o  (tx_data_o),
        .tx_ready_i (tx_ready_i)
    );

endmodule

`default_nettype wire

// ==== src.f ====
hw/link_pkg.sv
hw/scan_cfg_pkg.sv
hw/scan_ctrl_ifs.sv
hw/crc8_calc.sv
hw/frame_decode.sv
hw/cfg_execute.sv
hw/reply_result.sv
hw/scan_ctrl_top.sv
verification/tb_scan_ctrl.sv

// ==== verification/tb_scan_ctrl.sv ====
`default_nettype none

module tb_scan_ctrl;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PAYLOAD_BYTES = 26;
    localparam int FRAME_LEN     = PAYLOAD_BYTES + 3;
    localparam int CLK_PERIOD    = 40;
    localparam int NUM_FRAMES    = 30; // frames in and out, rounded up
    localparam int REPLY_LIMIT   = FRAME_LEN * 16;
    // three cycles per byte leaves room for back-pressure and quiet windows
    localparam int WATCHDOG_NS   = NUM_FRAMES * FRAME_LEN * 3 * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        reset;
    logic        rx_valid_i;
    logic [7:0]  rx_data_i;
    logic        tx_valid_o;
    logic [7:0]  tx_data_o;
    logic        tx_ready_i;
    logic        crc_err_o;
    logic [2:0]  start_o;
    logic [15:0] nx_pix_o;
    logic [15:0] ny_pix_o;
    logic [31:0] pixel_time_o;

    logic [7:0]  bank_m [4][PAYLOAD_BYTES]; // expected bank contents
    logic [7:0]  frame_pl [PAYLOAD_BYTES];
    logic [7:0]  rx_frame [FRAME_LEN];
    int          used_m [4] = '{16, 18, 19, 13};
    logic [31:0] rng = 32'd4082;
    logic        err_seen;
    int          value_errors = 0;
    int          other_errors = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    scan_ctrl_top #(.PAYLOAD_BYTES(PAYLOAD_BYTES)) u_dut (
        .clk          (clk),
        .reset        (reset),
        .rx_valid_i   (rx_valid_i),
        .rx_data_i    (rx_data_i),
        .tx_valid_o   (tx_valid_o),
        .tx_data_o    (tx_data_o),
        .tx_ready_i   (tx_ready_i),
        .crc_err_o    (crc_err_o),
        .start_o      (start_o),
        .nx_pix_o     (nx_pix_o),
        .ny_pix_o     (ny_pix_o),
        .pixel_time_o (pixel_time_o)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // poly 0x07, one bit at a time from the msb
    function automatic logic [7:0] crc8_byte(input logic [7:0] crc, input logic [7:0] d);
        logic [7:0] c;
        logic       fb;
        c = crc;
        for (int b = 7; b >= 0; b--) begin
            fb = c[7] ^ d[b];
            c  = {c[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
        end
        return c;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        value_errors++;
        $display("ERR %0d ns %s got %h expected %h", $time, name, got, want);
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("FAILURE %0d ns %s", $time, what);
    endtask

    task automatic fill_random_payload();
        for (int i = 0; i < PAYLOAD_BYTES; i++) begin
            rng = xorshift(rng);
            frame_pl[i] = rng[7:0];
        end
    endtask

    task automatic store_bank(input int bank);
        for (int i = 0; i < used_m[bank]; i++) begin
            bank_m[bank][i] = frame_pl[i];
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(negedge clk);
        rx_valid_i = 1'b1;
        rx_data_i  = b;
    endtask

    // corrupt inverts the check byte
    task automatic send_frame(input logic [7:0] addr, input logic corrupt);
        logic [7:0] crc;
        crc = crc8_byte(8'h00, addr);
        send_byte(8'hA5);
        send_byte(addr);
        for (int i = 0; i < PAYLOAD_BYTES; i++) begin
            send_byte(frame_pl[i]);
            crc = crc8_byte(crc, frame_pl[i]);
        end
        send_byte(corrupt ? ~crc : crc);
        @(negedge clk);
        rx_valid_i = 1'b0;
        err_seen   = crc_err_o; // one cycle after the check byte
    endtask

    task automatic expect_reply(input int bank);
        int         n;
        int         cycles;
        logic [7:0] crc;
        logic [7:0] want;
        n      = 0;
        cycles = 0;
        while (n < FRAME_LEN && cycles < REPLY_LIMIT) begin
            @(negedge clk);
            rng        = xorshift(rng);
            tx_ready_i = (rng[1:0] != 2'b00);
            if (tx_valid_o && tx_ready_i) begin
                rx_frame[n] = tx_data_o; // moves on the next rising edge
                n++;
            end
            cycles++;
        end
        @(negedge clk);
        tx_ready_i = 1'b0;
        if (n < FRAME_LEN) begin
            report_failure($sformatf("reply for bank %0d stopped after %0d bytes", bank, n));
            return;
        end
        if (rx_frame[0] != 8'hA5) report_mismatch("reply header", rx_frame[0], 8'hA5);
        if (rx_frame[1] != 8'(bank)) report_mismatch("reply address", rx_frame[1], 8'(bank));
        crc = crc8_byte(8'h00, rx_frame[1]);
        for (int i = 0; i < PAYLOAD_BYTES; i++) begin
            want = (i < used_m[bank]) ? bank_m[bank][i] : 8'hF0;
            if (rx_frame[i + 2] != want) begin
                report_mismatch($sformatf("reply payload[%0d]", i), rx_frame[i + 2], want);
            end
            crc = crc8_byte(crc, rx_frame[i + 2]);
        end
        if (rx_frame[FRAME_LEN - 1] != crc) begin
            report_mismatch("reply crc", rx_frame[FRAME_LEN - 1], crc);
        end
    endtask

    // no reply, start pulse or crc error may show up
    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (tx_valid_o) report_failure("reply frame sent where none was due");
            if (start_o != 3'b000) report_mismatch("start_o", start_o, 3'b000);
            if (crc_err_o) report_failure("crc_err_o high where no frame ended");
        end
    endtask

    task automatic check_scan_outputs();
        logic [15:0] nx;
        logic [15:0] ny;
        logic [31:0] pt;
        nx = {bank_m[0][0], bank_m[0][1]};
        ny = {bank_m[0][2], bank_m[0][3]};
        pt = {bank_m[0][12], bank_m[0][13], bank_m[0][14], bank_m[0][15]};
        if (nx_pix_o != nx) report_mismatch("nx_pix_o", nx_pix_o, nx);
        if (ny_pix_o != ny) report_mismatch("ny_pix_o", ny_pix_o, ny);
        if (pixel_time_o != pt) report_mismatch("pixel_time_o", pixel_time_o, pt);
    endtask

    task automatic check_start_pulse(input int bit_idx);
        int high;
        high = 0;
        repeat (12) begin
            @(negedge clk);
            if (start_o != 3'b000) begin
                high++;
                if (start_o != 3'(1 << bit_idx)) begin
                    report_mismatch("start_o", start_o, 3'(1 << bit_idx));
                end
            end
            if (tx_valid_o) report_failure("reply sent for a start command");
        end
        if (high != 4) report_mismatch("start_o pulse length", high, 4);
    endtask

    task automatic scan_write_reply();
        fill_random_payload();
        send_frame(8'h00, 1'b0);
        store_bank(0);
        expect_reply(0);
        check_scan_outputs();
    endtask

    task automatic config_banks_reply();
        for (int b = 1; b < 4; b++) begin
            fill_random_payload();
            send_frame(8'(b), 1'b0);
            store_bank(b);
            expect_reply(b);
        end
    endtask

    task automatic bad_crc_ignored();
        fill_random_payload();
        send_frame(8'h00, 1'b1);
        if (err_seen !== 1'b1) report_mismatch("crc_err_o", err_seen, 1'b1);
        expect_quiet(2 * FRAME_LEN);
        check_scan_outputs(); // bank untouched
        fill_random_payload();
        send_frame(8'h03, 1'b0);
        if (err_seen !== 1'b0) report_mismatch("crc_err_o", err_seen, 1'b0);
        store_bank(3);
        expect_reply(3);
    endtask

    task automatic start_pulses();
        for (int s = 0; s < 3; s++) begin
            fill_random_payload();
            send_frame(8'(4 + s), 1'b0);
            check_start_pulse(s);
        end
    endtask

    // second write waits in req while the first reply is stalled, third is dropped
    task automatic drop_while_reply_pending();
        tx_ready_i = 1'b0;
        fill_random_payload();
        send_frame(8'h01, 1'b0);
        store_bank(1);
        fill_random_payload();
        send_frame(8'h03, 1'b0);
        store_bank(3);
        fill_random_payload();
        send_frame(8'h00, 1'b0);
        repeat (4) @(negedge clk);
        check_scan_outputs();
        expect_reply(1);
        expect_reply(3);
        expect_quiet(2 * FRAME_LEN);
    endtask

    task automatic stray_bytes_and_unknown_address();
        send_byte(8'h00);
        send_byte(8'h5A);
        send_byte(8'hFF);
        fill_random_payload();
        send_frame(8'h07, 1'b0);
        if (err_seen !== 1'b0) report_mismatch("crc_err_o", err_seen, 1'b0);
        expect_quiet(2 * FRAME_LEN);
        check_scan_outputs();
        send_byte(8'h3C);
        send_byte(8'hA4);
        scan_write_reply();
    endtask

    initial begin
        reset      = 1'b1;
        rx_valid_i = 1'b0;
        rx_data_i  = 8'h00;
        tx_ready_i = 1'b0;
        err_seen   = 1'b0;
        for (int b = 0; b < 4; b++) begin
            for (int i = 0; i < PAYLOAD_BYTES; i++) begin
                bank_m[b][i] = 8'h00;
            end
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;
        if (tx_valid_o) report_failure("tx_valid_o high after reset");
        if (start_o != 3'b000) report_mismatch("start_o", start_o, 3'b000);
        if (crc_err_o) report_failure("crc_err_o high after reset");
        check_scan_outputs(); // banks cleared by reset

        scan_write_reply();
        config_banks_reply();
        bad_crc_ignored();
        start_pulses();
        drop_while_reply_pending();
        stray_bytes_and_unknown_address();

        $display("closing: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
